// File: compile.f
+incdir+tests
source/rescale_pkg.sv
source/range_check.sv
source/scale_shift.sv
source/saturate_select.sv
source/rescale.sv
tests/rescale_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rescale testbench with Verilator.
# Exits 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=rescale_sim
LOG_FILE=sim.log

echo "building with verilator"
verilator --binary --timing \
    -f compile.f \
    --top-module rescale_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_EXE"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

if [ ! -x "$BUILD_DIR/$SIM_EXE" ]; then
    echo "simulation executable missing"
    exit 1
fi

echo "running simulation"
"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -qx "No errors" "$LOG_FILE"
status=$?
if [ $status -eq 0 ]; then
    echo "result: pass"
    exit 0
else
    echo "result: fail, see $LOG_FILE"
    exit 1
fi

// File: tests/rescale_vectors.svh
// rescale vector table with the directed samples and the reference model for expected outputs
`ifndef RESCALE_VECTORS_SVH
`define RESCALE_VECTORS_SVH

// one entry per cycle, columns are valid, accumulator word, shift, head
logic                 vec_valid_q[$];
logic [NUM_WIDTH-1:0] vec_data_q[$];
logic [CFG_WIDTH-1:0] vec_shift_q[$];
logic [CFG_WIDTH-1:0] vec_head_q[$];

task automatic add_vector(
    input logic                 valid,
    input logic [NUM_WIDTH-1:0] data,
    input logic [CFG_WIDTH-1:0] shift_amt,
    input logic [CFG_WIDTH-1:0] head_pos
);
    vec_valid_q.push_back(valid);
    vec_data_q.push_back(data);
    vec_shift_q.push_back(shift_amt);
    vec_head_q.push_back(head_pos);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic load_vector_table();
    // in range words for shifts of 0, 1, 8 and 17
    add_vector(1'b1, 33'h0_0000_1234, 8'd0,  8'd16);
    add_vector(1'b1, 33'h0_0000_2468, 8'd1,  8'd16);
    add_vector(1'b1, 33'h1_FFFF_EDCC, 8'd0,  8'd16);
    add_vector(1'b1, 33'h1_FFFF_8000, 8'd8,  8'd16);
    add_vector(1'b1, 33'h0_0012_3456, 8'd17, 8'd24);
    add_vector(1'b1, 33'h1_FF80_0000, 8'd17, 8'd24);
    add_vector(1'b1, 33'h0_0000_FFFF, 8'd0,  8'd16);
    // positive overflow, the first one has its only set bit exactly at head
    add_vector(1'b1, 33'h0_0001_0000, 8'd0,  8'd16);
    add_vector(1'b1, 33'h0_4000_0000, 8'd8,  8'd20);
    add_vector(1'b1, 33'h0_8000_0000, 8'd0,  8'd31);
    // negative overflow
    add_vector(1'b1, 33'h1_FFFE_FFFF, 8'd0,  8'd16);
    add_vector(1'b1, 33'h1_0000_0000, 8'd0,  8'd0);
    add_vector(1'b1, 33'h1_7FFF_FFFF, 8'd4,  8'd31);
    // heads above 31 switch the check off, so words pass truncated
    add_vector(1'b1, 33'h0_8000_1234, 8'd0,  8'd32);
    add_vector(1'b1, 33'h1_0000_5678, 8'd0,  8'd40);
    // settings change every cycle with gaps of low valid in between
    add_vector(1'b0, 33'h1_2345_6789, 8'd3,  8'd5);
    add_vector(1'b1, 33'h0_0000_0F00, 8'd4,  8'd12);
    add_vector(1'b1, 33'h0_0000_1F00, 8'd2,  8'd12);
    add_vector(1'b0, 33'h0_FFFF_FFFF, 8'd0,  8'd0);
    add_vector(1'b0, 33'h1_0000_0001, 8'd9,  8'd2);
    add_vector(1'b1, 33'h1_FFFF_F000, 8'd1,  8'd13);
    add_vector(1'b1, 33'h0_0003_0000, 8'd33, 8'd18);
    add_vector(1'b1, 33'h0_0003_0000, 8'd16, 8'd17);
    add_vector(1'b0, 33'h0_0000_0000, 8'd0,  8'd0);
    add_vector(1'b1, 33'h1_FFFF_FFFF, 8'd17, 8'd0);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// a word saturates when the field from bit NUM_WIDTH-2 down to head
// is not a copy of the sign, otherwise it is shifted and truncated
function automatic logic [IMG_WIDTH-1:0] expected_sample(
    input logic [NUM_WIDTH-1:0] data,
    input logic [CFG_WIDTH-1:0] shift_amt,
    input logic [CFG_WIDTH-1:0] head_pos
);
    logic [NUM_WIDTH-1:0] field_mask;
    logic [NUM_WIDTH-1:0] shifted;
    logic [IMG_WIDTH-1:0] result;
    logic                 sign;
    logic                 saturate;
    sign     = data[NUM_WIDTH-1];
    saturate = 1'b0;
    if (int'(head_pos) <= NUM_WIDTH - 2) begin
        field_mask = {1'b0, {(NUM_WIDTH-1){1'b1}}} & ({NUM_WIDTH{1'b1}} << head_pos);
        if (sign) begin
            saturate = ((data & field_mask) != field_mask);
        end else begin
            saturate = ((data & field_mask) != '0);
        end
    end
    shifted = data >> shift_amt;
    if (saturate) begin
        result = sign ? IMG_MIN : IMG_MAX;
    end else begin
        result = shifted[IMG_WIDTH-1:0];
    end
    return result;
endfunction

`endif

// File: tests/rescale_tb.sv
// testbench for the rescale stage, applying directed and random samples against a reference model
`timescale 1ns/1ps
`default_nettype none

module rescale_tb import rescale_pkg::*; ();

    localparam int RANDOM_COUNT = 200;

    logic                 clk;
    logic                 rst_n;
    logic                 up_valid;
    logic [NUM_WIDTH-1:0] up_data;
    logic [CFG_WIDTH-1:0] shift;
    logic [CFG_WIDTH-1:0] head;
    logic                 dn_valid;
    logic [IMG_WIDTH-1:0] dn_data;

    // expected results and the cycle each sample was driven
    logic [IMG_WIDTH-1:0] exp_data_q[$];
    int                   exp_stamp_q[$];
    logic [IMG_WIDTH-1:0] exp_data;
    int                   exp_stamp;

    int     cycle_count = 0;
    int     timeout_limit = 0;
    int     error_count = 0;
    int     monitor_errors = 0;
    int     compare_count = 0;
    integer seed;
    logic [31:0] rand_lo;
    logic [31:0] rand_hi;

    `include "rescale_vectors.svh"

    rescale u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .shift    (shift),
        .head     (head),
        .up_valid (up_valid),
        .up_data  (up_data),
        .dn_valid (dn_valid),
        .dn_data  (dn_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // drive one sample just after the edge and queue its expected result
    task automatic apply_sample(
        input logic                 valid,
        input logic [NUM_WIDTH-1:0] data,
        input logic [CFG_WIDTH-1:0] shift_amt,
        input logic [CFG_WIDTH-1:0] head_pos
    );
        @(posedge clk);
        #1;
        up_valid = valid;
        up_data  = data;
        shift    = shift_amt;
        head     = head_pos;
        if (valid) begin
            exp_data_q.push_back(expected_sample(data, shift_amt, head_pos));
            exp_stamp_q.push_back(cycle_count);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output monitor sampled on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && dn_valid) begin
                if (exp_data_q.size() == 0) begin
                    $display("dn_valid went high with no sample waiting at cycle %0d", cycle_count);
                    monitor_errors++;
                end else begin
                    exp_data  = exp_data_q.pop_front();
                    exp_stamp = exp_stamp_q.pop_front();
                    compare_count++;
                    if (dn_data !== exp_data) begin
                        $display("error dn_data expected %h actual %h", exp_data, dn_data);
                        monitor_errors++;
                    end
                    if (cycle_count - exp_stamp != PIPE_DEPTH) begin
                        $display("sample took %0d cycles to come out instead of %0d",
                                 cycle_count - exp_stamp, PIPE_DEPTH);
                        monitor_errors++;
                    end
                end
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if ((timeout_limit > 0) && (cycle_count >= timeout_limit)) begin
                $display("run stopped by timeout after %0d cycles", cycle_count);
                $display("compared %0d samples, %0d errors", compare_count,
                         error_count + monitor_errors + 1);
                $display("Errors found");
                $finish;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        // a live sample sits on the inputs during reset so that only the
        // reset itself can keep the outputs clear afterwards
        rst_n    = 1'b0;
        up_valid = 1'b1;
        up_data  = 33'h1_2345_6789;
        shift    = 8'd3;
        head     = 8'd40;
        seed     = 32'ha5421b9e;
        load_vector_table();
        timeout_limit = vec_data_q.size() + RANDOM_COUNT + PIPE_DEPTH + 20;

        repeat (4) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        up_valid = 1'b0;
        up_data  = '0;
        shift    = '0;
        head     = '0;

        // nothing may come out while the inputs idle after reset
        repeat (PIPE_DEPTH) begin
            @(negedge clk);
            if (dn_valid !== 1'b0) begin
                $display("error dn_valid expected %h actual %h", 1'b0, dn_valid);
                error_count++;
            end
            if (dn_data !== '0) begin
                $display("error dn_data expected %h actual %h", 16'h0000, dn_data);
                error_count++;
            end
        end

        for (int i = 0; i < vec_data_q.size(); i++) begin
            apply_sample(vec_valid_q[i], vec_data_q[i], vec_shift_q[i], vec_head_q[i]);
        end

        // half of the random words are small enough to stay in range
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            rand_lo = $random(seed);
            rand_hi = $random(seed);
            if (rand_hi[24]) begin
                apply_sample(1'b1, {{17{rand_lo[15]}}, rand_lo[15:0]},
                             {3'b000, rand_hi[20:16]}, {2'b00, rand_hi[13:8]});
            end else begin
                apply_sample(1'b1, {rand_hi[0], rand_lo},
                             {3'b000, rand_hi[20:16]}, {2'b00, rand_hi[13:8]});
            end
        end
        apply_sample(1'b0, '0, '0, '0);

        // the latency is fixed, so the last sample is out after this
        repeat (PIPE_DEPTH + 2) @(posedge clk);
        if (exp_data_q.size() != 0) begin
            $display("%0d samples never came out of the DUT", exp_data_q.size());
            error_count++;
        end

        $display("compared %0d samples, %0d errors", compare_count,
                 error_count + monitor_errors);
        if ((error_count + monitor_errors) == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/rescale.sv
// output rescale stage turning a 33-bit accumulator word into a saturated 16-bit image sample
`timescale 1ns/1ps
`default_nettype none

module rescale import rescale_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,

    // per-sample settings travel alongside the word
    input  wire  [CFG_WIDTH-1:0] shift,
    input  wire  [CFG_WIDTH-1:0] head,

    input  wire                  up_valid,
    input  wire  [NUM_WIDTH-1:0] up_data,

    output logic                 dn_valid,
    output logic [IMG_WIDTH-1:0] dn_data
);

    logic                 bound_max;
    logic                 bound_min;
    logic                 scaled_valid;
    logic [IMG_WIDTH-1:0] scaled_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // range check and scaling run side by side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    range_check u_range_check (
        .clk       (clk),
        .rst_n     (rst_n),
        .up_data   (up_data),
        .head      (head),
        .bound_max (bound_max),
        .bound_min (bound_min)
    );

    scale_shift u_scale_shift (
        .clk          (clk),
        .rst_n        (rst_n),
        .up_valid     (up_valid),
        .up_data      (up_data),
        .shift        (shift),
        .scaled_valid (scaled_valid),
        .scaled_data  (scaled_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // merge into the saturated output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    saturate_select u_saturate_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .scaled_valid (scaled_valid),
        .scaled_data  (scaled_data),
        .bound_max    (bound_max),
        .bound_min    (bound_min),
        .dn_valid     (dn_valid),
        .dn_data      (dn_data)
    );

endmodule

`default_nettype wire

// File: source/saturate_select.sv
// saturation selector choosing the image limit or the scaled value and registering the output
`timescale 1ns/1ps
`default_nettype none

module saturate_select import rescale_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  scaled_valid,
    input  wire  [IMG_WIDTH-1:0] scaled_data,
    input  wire                  bound_max,
    input  wire                  bound_min,
    output logic                 dn_valid,
    output logic [IMG_WIDTH-1:0] dn_data
);

    logic [IMG_WIDTH-1:0] sel_data_p3;
    logic                 sel_valid_p3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage three picks the result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the flags and the scaled word arrive on the same cycle since both
    // upstream blocks are two stages deep
    // only one flag can be set for a sample, so the order of the tests is free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_data_p3  <= '0;
            sel_valid_p3 <= 1'b0;
        end else begin
            if (bound_min) begin
                sel_data_p3 <= IMG_MIN;
            end else if (bound_max) begin
                sel_data_p3 <= IMG_MAX;
            end else begin
                sel_data_p3 <= scaled_data;
            end
            sel_valid_p3 <= scaled_valid;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage four registers the output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // gives the downstream layer a clean flop to time from
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dn_data  <= '0;
            dn_valid <= 1'b0;
        end else begin
            dn_data  <= sel_data_p3;
            dn_valid <= sel_valid_p3;
        end
    end

endmodule

`default_nettype wire

// File: source/scale_shift.sv
// scaler shifting the accumulator word right and truncating it to the image width
`timescale 1ns/1ps
`default_nettype none

module scale_shift import rescale_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 up_valid,
    input  wire [NUM_WIDTH-1:0] up_data,
    input  wire [CFG_WIDTH-1:0] shift,
    output logic                scaled_valid,
    output logic [IMG_WIDTH-1:0] scaled_data
);

    logic [NUM_WIDTH-1:0] shifted_p1;
    logic                 valid_p1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage one, shift the full word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // logical shift, negative words fill with zeros from the top
    // shifts of NUM_WIDTH or more leave an all zero word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shifted_p1 <= '0;
            valid_p1   <= 1'b0;
        end else begin
            shifted_p1 <= up_data >> shift;
            valid_p1   <= up_valid;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage two, truncate to the image width
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // plain truncation, the dropped low bits are not rounded in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scaled_data  <= '0;
            scaled_valid <= 1'b0;
        end else begin
            scaled_data  <= shifted_p1[IMG_WIDTH-1:0];
            scaled_valid <= valid_p1;
        end
    end

endmodule

`default_nettype wire

// File: source/range_check.sv
// range checker flagging accumulator words that overflow the image range above the head bit
`timescale 1ns/1ps
`default_nettype none

module range_check import rescale_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire [NUM_WIDTH-1:0] up_data,
    input  wire [CFG_WIDTH-1:0] head,
    output logic                bound_max,
    output logic                bound_min
);

    // word and head held together so the scan sees a matched pair
    logic [NUM_WIDTH-1:0] data_p1;
    logic [CFG_WIDTH-1:0] head_p1;

    logic                 sign_p1;
    logic                 overflow_p1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage one, capture the sample
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_p1 <= '0;
            head_p1 <= '0;
        end else begin
            data_p1 <= up_data;
            head_p1 <= head;
        end
    end

    assign sign_p1 = data_p1[NUM_WIDTH-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage two, scan the upper bits against the sign
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a word fits when every bit from just below the sign down to head
    // is a copy of the sign, any other value is out of range
    // a head above NUM_WIDTH-2 leaves nothing to scan, so nothing overflows
    always_comb begin
        overflow_p1 = 1'b0;
        for (int i = 0; i < NUM_WIDTH-1; i++) begin
            if ((i >= int'(head_p1)) && (data_p1[i] != sign_p1)) begin
                overflow_p1 = 1'b1;
            end
        end
    end

    // the sign picks which limit is hit, so at most one flag is ever set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bound_max <= 1'b0;
            bound_min <= 1'b0;
        end else begin
            bound_max <= overflow_p1 & ~sign_p1;
            bound_min <= overflow_p1 & sign_p1;
        end
    end

endmodule

`default_nettype wire

// File: source/rescale_pkg.sv
// rescale package holding the word widths, image saturation limits and pipeline latency
`default_nettype none

package rescale_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // accumulator word from the MAC/ADD tree, sign in the top bit
    localparam int NUM_WIDTH = 33;

    // image sample handed to the next layer
    localparam int IMG_WIDTH = 16;

    // per-sample shift and head settings share one width
    localparam int CFG_WIDTH = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // saturation limits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // most positive two's complement image value
    localparam logic [IMG_WIDTH-1:0] IMG_MAX = {1'b0, {(IMG_WIDTH-1){1'b1}}};

    // most negative two's complement image value
    localparam logic [IMG_WIDTH-1:0] IMG_MIN = {1'b1, {(IMG_WIDTH-1){1'b0}}};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // cycles from a sample on up_data to its result on dn_data
    // two stages for the range check and scaler in parallel, two for the selector
    localparam int PIPE_DEPTH = 4;

endpackage

`default_nettype wire
